/* include/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width
`define RV_XLEN 64

// Architectural register file
`define RV_REG_COUNT 32
`define RV_REG_AW 5

// First fetch after reset
`define RV_RESET_PC 64'h0000_0000_0000_0000

// PC step between sequential instructions
`define RV_INSTR_BYTES 4

`endif

/* source/rv_pkg.sv */
`include "rv_config.svh"

package rv_pkg;

   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JALR   = 7'b1100111,
      LUI    = 7'b0110111
   } opcode_e;

   typedef enum logic [3:0] {
      ST_RESET, ST_FETCH, ST_FETCH_WAIT, ST_DECODE, ST_EXECUTE, ST_WRITEBACK,
      ST_ADDR, ST_MEM_READ, ST_MEM_WAIT, ST_LOAD_WB, ST_MEM_WRITE, ST_BRANCH,
      ST_JALR_LINK, ST_JALR_JUMP
   } state_e;

   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_SLT, ALU_PASS_B} alu_op_e;

   // Operand, write-back and PC selects
   localparam logic [1:0] SRC_A_REG    = 2'd0;
   localparam logic [1:0] SRC_A_PC     = 2'd1;
   localparam logic [1:0] SRC_A_ZERO   = 2'd2;
   localparam logic [1:0] SRC_B_REG    = 2'd0;
   localparam logic [1:0] SRC_B_IMM    = 2'd1;
   localparam logic [1:0] SRC_B_FOUR   = 2'd2;
   localparam logic [1:0] SRC_B_BRANCH = 2'd3;
   localparam logic [1:0] WB_ALU       = 2'd0;
   localparam logic [1:0] WB_MDR       = 2'd1;
   localparam logic [1:0] WB_PC        = 2'd2;
   localparam logic       PC_SRC_ALU    = 1'b0;   // Live ALU result
   localparam logic       PC_SRC_TARGET = 1'b1;   // ALU output register

   typedef struct packed {
      logic       ir_load;
      logic       pc_write;
      logic       pc_src;
      logic       ab_load;
      logic       alu_out_load;
      logic       mdr_load;
      logic [1:0] alu_src_a;
      logic [1:0] alu_src_b;
      alu_op_e    alu_op;
      logic       reg_write;
      logic [1:0] wb_src;
      logic       dmem_re;
      logic       dmem_we;
   } ctrl_t;

   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] funct3;
      logic       funct7_b5;
      logic       eq;
      logic       lt;      // Signed compare
   } status_t;

   typedef struct packed {
      logic [`RV_XLEN-1:0] addr;
   } imem_req_t;

   typedef struct packed {
      logic [`RV_XLEN-1:0] addr;
      logic [`RV_XLEN-1:0] wdata;
      logic                re;
      logic                we;
   } dmem_req_t;

endpackage

/* source/rv_alu.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_alu (
   input  logic [`RV_XLEN-1:0] a,
   input  logic [`RV_XLEN-1:0] b,
   input  rv_pkg::alu_op_e     op,
   output logic [`RV_XLEN-1:0] result,
   output logic                eq,
   output logic                lt
);
   import rv_pkg::*;

   assign eq = (a == b);
   assign lt = ($signed(a) < $signed(b));

   always_comb
   begin
      case (op)
         ALU_ADD:
            result = a + b;
         ALU_SUB:
            result = a - b;
         ALU_SLT:
            result = {{(`RV_XLEN-1){1'b0}}, lt};   // Same flag the branches use
         ALU_PASS_B:
            result = b;                           // LUI
         default:
            result = a + b;
      endcase
   end

endmodule

/* source/rv_regfile.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_regfile (
   input  logic                  CLK,
   input  logic                  RESET,
   input  logic [`RV_REG_AW-1:0] rs1,
   input  logic [`RV_REG_AW-1:0] rs2,
   input  logic [`RV_REG_AW-1:0] rd,
   input  logic                  we,
   input  logic [`RV_XLEN-1:0]   wdata,
   output logic [`RV_XLEN-1:0]   rdata1,
   output logic [`RV_XLEN-1:0]   rdata2
);
   logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

   assign rdata1 = regs[rs1];
   assign rdata2 = regs[rs2];

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         for (int i = 0; i < `RV_REG_COUNT; i++)
            regs[i] <= '0;
      end
      else if (we && (rd != '0))   // x0 never written
         regs[rd] <= wdata;
   end

endmodule

/* source/rv_imm_gen.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_imm_gen (
   input  logic [31:0]         instr,
   output logic [`RV_XLEN-1:0] imm,
   output logic [`RV_XLEN-1:0] branch_imm
);
   import rv_pkg::*;

   logic [`RV_XLEN-1:0] imm_i;
   logic [`RV_XLEN-1:0] imm_s;
   logic [`RV_XLEN-1:0] imm_u;
   logic [`RV_XLEN-1:0] imm_b;

   assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
   assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_u = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'h000};
   assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0};

   // PC has already moved past the branch by the time the target is formed
   assign branch_imm = imm_b - `RV_XLEN'(`RV_INSTR_BYTES);

   always_comb
   begin
      case (opcode_e'(instr[6:0]))
         STORE:
            imm = imm_s;
         LUI:
            imm = imm_u;
         default:
            imm = imm_i;   // OP_IMM, LOAD and JALR
      endcase
   end

endmodule

/* source/rv_datapath.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_datapath (
   input  logic                CLK,
   input  logic                RESET,
   input  rv_pkg::ctrl_t       ctrl,
   output rv_pkg::status_t     status,
   output rv_pkg::imem_req_t   imem_req,
   input  logic [31:0]         imem_rdata,
   output rv_pkg::dmem_req_t   dmem_req,
   input  logic [`RV_XLEN-1:0] dmem_rdata
);
   import rv_pkg::*;

   logic [`RV_XLEN-1:0] pc;
   logic [31:0]         ir;
   logic [`RV_XLEN-1:0] a_reg;
   logic [`RV_XLEN-1:0] b_reg;
   logic [`RV_XLEN-1:0] alu_out;
   logic [`RV_XLEN-1:0] mdr;
   logic [`RV_XLEN-1:0] rdata1;
   logic [`RV_XLEN-1:0] rdata2;
   logic [`RV_XLEN-1:0] wb_data;
   logic [`RV_XLEN-1:0] imm;
   logic [`RV_XLEN-1:0] branch_imm;
   logic [`RV_XLEN-1:0] alu_a;
   logic [`RV_XLEN-1:0] alu_b;
   logic [`RV_XLEN-1:0] alu_result;
   logic [`RV_XLEN-1:0] pc_target;
   logic                alu_eq;
   logic                alu_lt;

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
         pc <= `RV_RESET_PC;
      else if (ctrl.pc_write)
         pc <= {pc_target[`RV_XLEN-1:1], 1'b0};   // Bit 0 cleared for JALR
   end

   always_ff @(posedge CLK)
   begin
      if (ctrl.ir_load)
         ir <= imem_rdata;
      if (ctrl.ab_load)
      begin
         a_reg <= rdata1;
         b_reg <= rdata2;
      end
      if (ctrl.alu_out_load)
         alu_out <= alu_result;
      if (ctrl.mdr_load)
         mdr <= dmem_rdata;
   end

   assign pc_target = (ctrl.pc_src == PC_SRC_TARGET) ? alu_out : alu_result;

   always_comb
   begin
      case (ctrl.alu_src_a)
         SRC_A_PC:   alu_a = pc;
         SRC_A_ZERO: alu_a = '0;
         default:    alu_a = a_reg;
      endcase
      case (ctrl.alu_src_b)
         SRC_B_IMM:    alu_b = imm;
         SRC_B_FOUR:   alu_b = `RV_XLEN'(`RV_INSTR_BYTES);
         SRC_B_BRANCH: alu_b = branch_imm;
         default:      alu_b = b_reg;
      endcase
      case (ctrl.wb_src)
         WB_MDR:  wb_data = mdr;
         WB_PC:   wb_data = pc;   // Already the return address
         default: wb_data = alu_out;
      endcase
   end

   rv_regfile u_regfile (
      .CLK    (CLK),
      .RESET  (RESET),
      .rs1    (ir[19:15]),
      .rs2    (ir[24:20]),
      .rd     (ir[11:7]),
      .we     (ctrl.reg_write),
      .wdata  (wb_data),
      .rdata1 (rdata1),
      .rdata2 (rdata2)
   );

   rv_imm_gen u_imm_gen (
      .instr      (ir),
      .imm        (imm),
      .branch_imm (branch_imm)
   );

   rv_alu u_alu (
      .a      (alu_a),
      .b      (alu_b),
      .op     (ctrl.alu_op),
      .result (alu_result),
      .eq     (alu_eq),
      .lt     (alu_lt)
   );

   always_comb
   begin
      status.opcode    = opcode_e'(ir[6:0]);
      status.funct3    = ir[14:12];
      status.funct7_b5 = ir[30];
      status.eq        = alu_eq;
      status.lt        = alu_lt;
      imem_req.addr    = pc;
      dmem_req.addr    = alu_out;   // Effective address from ST_ADDR
      dmem_req.wdata   = b_reg;
      dmem_req.re      = ctrl.dmem_re;
      dmem_req.we      = ctrl.dmem_we;
   end

endmodule

/* source/rv_control.sv */
`timescale 1ns/10ps

module rv_control (
   input  logic            CLK,
   input  logic            RESET,
   input  rv_pkg::status_t status,
   output rv_pkg::ctrl_t   ctrl
);
   import rv_pkg::*;

   state_e  state;
   state_e  state_next;
   alu_op_e exec_op;
   logic    arith_f3;
   logic    dword_f3;
   logic    taken;

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
         state <= ST_RESET;
      else
         state <= state_next;
   end

   assign arith_f3 = (status.funct3 == 3'd0) || (status.funct3 == 3'd2);   // ADD/SUB or SLT
   assign dword_f3 = (status.funct3 == 3'd3);

   always_comb
   begin
      exec_op = ALU_ADD;
      case (status.opcode)
         OP:
         begin
            if (status.funct3 == 3'd2)
               exec_op = ALU_SLT;
            else if (status.funct7_b5)
               exec_op = ALU_SUB;
         end
         OP_IMM:
         begin
            if (status.funct3 == 3'd2)
               exec_op = ALU_SLT;
         end
         LUI:
            exec_op = ALU_PASS_B;
         default:
            exec_op = ALU_ADD;
      endcase
   end

   always_comb
   begin
      case (status.funct3)
         3'd0:    taken = status.eq;    // BEQ
         3'd1:    taken = !status.eq;   // BNE
         3'd4:    taken = status.lt;    // BLT
         3'd5:    taken = !status.lt;   // BGE
         default: taken = 1'b0;
      endcase
   end

   always_comb
   begin
      ctrl = '0;
      ctrl.alu_src_a = SRC_A_ZERO;
      state_next = ST_FETCH;
      case (state)
         ST_RESET:
            state_next = ST_FETCH;
         ST_FETCH:
            state_next = ST_FETCH_WAIT;   // Address out, data next cycle
         ST_FETCH_WAIT:
         begin
            ctrl.ir_load = 1'b1;
            ctrl.pc_write = 1'b1;
            ctrl.pc_src = PC_SRC_ALU;
            ctrl.alu_src_a = SRC_A_PC;
            ctrl.alu_src_b = SRC_B_FOUR;
            state_next = ST_DECODE;
         end
         ST_DECODE:
         begin
            ctrl.ab_load = 1'b1;
            ctrl.alu_out_load = 1'b1;   // Branch target ahead of time
            ctrl.alu_src_a = SRC_A_PC;
            ctrl.alu_src_b = SRC_B_BRANCH;
            case (status.opcode)
               OP, OP_IMM:
                  state_next = arith_f3 ? ST_EXECUTE : ST_FETCH;
               LUI:
                  state_next = ST_EXECUTE;
               LOAD, STORE:
                  state_next = dword_f3 ? ST_ADDR : ST_FETCH;
               BRANCH:
                  state_next = ST_BRANCH;
               JALR:
                  state_next = (status.funct3 == 3'd0) ? ST_JALR_LINK : ST_FETCH;
               default:
                  state_next = ST_FETCH;   // Unknown opcode is a no-op
            endcase
         end
         ST_EXECUTE:
         begin
            ctrl.alu_out_load = 1'b1;
            ctrl.alu_src_a = SRC_A_REG;
            ctrl.alu_src_b = (status.opcode == OP) ? SRC_B_REG : SRC_B_IMM;
            ctrl.alu_op = exec_op;
            state_next = ST_WRITEBACK;
         end
         ST_WRITEBACK:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.wb_src = WB_ALU;
         end
         ST_ADDR:
         begin
            ctrl.alu_out_load = 1'b1;
            ctrl.alu_src_a = SRC_A_REG;
            ctrl.alu_src_b = SRC_B_IMM;
            state_next = (status.opcode == LOAD) ? ST_MEM_READ : ST_MEM_WRITE;
         end
         ST_MEM_READ:
         begin
            ctrl.dmem_re = 1'b1;
            state_next = ST_MEM_WAIT;
         end
         ST_MEM_WAIT:
         begin
            ctrl.mdr_load = 1'b1;
            state_next = ST_LOAD_WB;
         end
         ST_LOAD_WB:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.wb_src = WB_MDR;
         end
         ST_MEM_WRITE:
            ctrl.dmem_we = 1'b1;
         ST_BRANCH:
         begin
            ctrl.alu_src_a = SRC_A_REG;   // rs1 against rs2 for the flags
            ctrl.alu_src_b = SRC_B_REG;
            ctrl.pc_write = taken;
            ctrl.pc_src = PC_SRC_TARGET;
         end
         ST_JALR_LINK:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.wb_src = WB_PC;
            state_next = ST_JALR_JUMP;
         end
         ST_JALR_JUMP:
         begin
            ctrl.alu_src_a = SRC_A_REG;   // A still holds the old rs1
            ctrl.alu_src_b = SRC_B_IMM;
            ctrl.pc_write = 1'b1;
            ctrl.pc_src = PC_SRC_ALU;
         end
         default:
            state_next = ST_FETCH;
      endcase
   end

endmodule

/* source/rv_core.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_core (
   input  logic                CLK,
   input  logic                RESET,
   output rv_pkg::imem_req_t   imem_req,
   input  logic [31:0]         imem_rdata,
   output rv_pkg::dmem_req_t   dmem_req,
   input  logic [`RV_XLEN-1:0] dmem_rdata
);
   import rv_pkg::*;

   ctrl_t   ctrl;
   status_t status;

   rv_control u_control (
      .CLK    (CLK),
      .RESET  (RESET),
      .status (status),
      .ctrl   (ctrl)
   );

   rv_datapath u_datapath (
      .CLK        (CLK),
      .RESET      (RESET),
      .ctrl       (ctrl),
      .status     (status),
      .imem_req   (imem_req),
      .imem_rdata (imem_rdata),
      .dmem_req   (dmem_req),
      .dmem_rdata (dmem_rdata)
   );

endmodule

/* sim/rv_core_props.sv */
`timescale 1ns/10ps

module rv_core_props (
   input logic              CLK,
   input logic              RESET,
   input rv_pkg::imem_req_t imem_req,
   input rv_pkg::dmem_req_t dmem_req
);
   int fail_count = 0;   // Read by the testbench at the end of the run

   a_rw_exclusive: assert property (@(posedge CLK) disable iff (RESET)
      !(dmem_req.re && dmem_req.we))
      else
      begin
         fail_count++;
         $error("Data memory read and write requested in the same cycle");
      end

   a_idle_after_reset: assert property (@(posedge CLK)
      $fell(RESET) |-> (!dmem_req.re && !dmem_req.we))
      else
      begin
         fail_count++;
         $error("Data memory request active in the cycle after reset");
      end

   a_fetch_aligned: assert property (@(posedge CLK) disable iff (RESET)
      imem_req.addr[1:0] == 2'b00)
      else
      begin
         fail_count++;
         $error("Fetch address %h is not word aligned", imem_req.addr);
      end

endmodule

bind rv_core rv_core_props u_props (
   .CLK      (CLK),
   .RESET    (RESET),
   .imem_req (imem_req),
   .dmem_req (dmem_req)
);

/* sim/rv_core_tb.sv */
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_core_tb;
   import rv_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int MEM_WORDS  = 64;
   localparam int MAX_STEPS  = 400;
   localparam int RCNT       = 28;   // Branch fall-through counter

   logic                CLK;
   logic                RESET;
   imem_req_t           imem_req;
   logic [31:0]         imem_rdata;
   dmem_req_t           dmem_req;
   logic [`RV_XLEN-1:0] dmem_rdata;

   logic [31:0]         imem [MEM_WORDS];
   logic [`RV_XLEN-1:0] dmem [MEM_WORDS];
   logic [`RV_XLEN-1:0] ref_dmem [MEM_WORDS];
   int                  section_of [MEM_WORDS];
   int                  prog_len = 0;
   integer              seed = 32'hf951f18e;

   imem_req_t           exp_fetch_q [$];
   int                  exp_gap_q [$];
   int                  exp_section_q [$];
   dmem_req_t           exp_store_q [$];

   string test_name [5] = '{"reset and setup", "arithmetic", "load and store",
                            "branches", "jalr"};
   int   cycle = 0;
   int   last_fetch = 0;
   int   fetches = 0;
   int   cur_test = 0;
   int   test_errors = 0;
   int   total_errors = 0;
   int   tests_passed = 0;
   int   tests_failed = 0;
   logic run_done = 1'b0;

   rv_core u_dut (
      .CLK        (CLK),
      .RESET      (RESET),
      .imem_req   (imem_req),
      .imem_rdata (imem_rdata),
      .dmem_req   (dmem_req),
      .dmem_rdata (dmem_rdata)
   );

   initial
   begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   // Both memories answer one cycle after the address
   always @(posedge CLK)
   begin
      imem_rdata <= imem[imem_req.addr[7:2]];
      if (dmem_req.we)
         dmem[dmem_req.addr[8:3]] <= dmem_req.wdata;
      if (dmem_req.re)
         dmem_rdata <= dmem[dmem_req.addr[8:3]];
      else
         dmem_rdata <= 'x;   // Data only follows a read request
   end

   function automatic logic [31:0] r_type(logic sub, int rs2, int rs1, logic [2:0] f3, int rd);
      return {1'b0, sub, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OP};
   endfunction

   function automatic logic [31:0] i_type(int imm, int rs1, logic [2:0] f3, int rd,
                                          opcode_e op);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
   endfunction

   function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'd3, imm[4:0], STORE};
   endfunction

   function automatic logic [31:0] b_type(int imm, int rs2, int rs1, logic [2:0] f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], BRANCH};
   endfunction

   function automatic logic [31:0] u_type(int imm20, int rd);
      return {imm20[19:0], rd[4:0], LUI};
   endfunction

   function automatic int rand_offset();
      return ({$random(seed)} % 32) * 8 - 256;   // Keeps x1 + offset inside data memory
   endfunction

   function automatic int rand_imm();
      return ({$random(seed)} % 4096) - 2048;
   endfunction

   function automatic int pick_dest();
      return 17 + {$random(seed)} % 8;
   endfunction

   task automatic emit(input logic [31:0] ins, input int sect);
      imem[prog_len] = ins;
      section_of[prog_len] = sect;
      prog_len++;
   endtask

   task automatic store_reg(input int rs, input int sect);
      emit(s_type(rand_offset(), rs, 1), sect);
   endtask

   task automatic branch_pair(input logic [2:0] f3, input int r1, input int r2);
      emit(b_type(8, r2, r1, f3), 3);                 // Taken skips the increment
      emit(i_type(1, RCNT, 3'd0, RCNT, OP_IMM), 3);
   endtask

   task automatic build_program();
      int ra;
      int rb;
      int rc;
      int rd;
      int jimm;
      int target;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         imem[i] = i_type(i, 0, 3'd0, 0, OP_IMM);   // Distinct no-ops
         dmem[i] = {$random(seed), $random(seed)};
         ref_dmem[i] = dmem[i];
         section_of[i] = 4;
      end
      ra = 5 + {$random(seed)} % 8;
      rb = 13 + {$random(seed)} % 4;
      rc = 25 + {$random(seed)} % 3;
      emit(i_type(256, 0, 3'd0, 1, OP_IMM), 0);      // Data base in x1
      emit(32'h0000_0000, 0);                        // Unknown opcode
      emit(i_type(-1 - ({$random(seed)} % 2047), 0, 3'd0, ra, OP_IMM), 1);
      emit(i_type(1 + ({$random(seed)} % 2047), 0, 3'd0, rb, OP_IMM), 1);
      emit(u_type($random(seed), rc), 1);
      rd = pick_dest();
      emit(r_type(1'b0, rb, ra, 3'd0, rd), 1);
      store_reg(rd, 1);
      rd = pick_dest();
      emit(r_type(1'b1, rb, ra, 3'd0, rd), 1);
      store_reg(rd, 1);
      rd = pick_dest();
      emit(r_type(1'b0, rb, ra, 3'd2, rd), 1);
      store_reg(rd, 1);
      rd = pick_dest();
      emit(r_type(1'b0, ra, rb, 3'd2, rd), 1);
      store_reg(rd, 1);
      rd = pick_dest();
      emit(i_type(rand_imm(), ra, 3'd2, rd, OP_IMM), 1);
      store_reg(rd, 1);
      rd = pick_dest();
      emit(i_type(rand_imm(), rc, 3'd0, rd, OP_IMM), 1);
      store_reg(rd, 1);
      store_reg(rc, 1);
      rd = pick_dest();
      emit(i_type(rand_offset(), 1, 3'd3, rd, LOAD), 2);
      emit(i_type(rand_imm(), rd, 3'd0, rd, OP_IMM), 2);
      store_reg(rd, 2);
      rd = pick_dest();
      emit(i_type(rand_offset(), 1, 3'd3, rd, LOAD), 2);
      emit(r_type(1'b1, ra, rd, 3'd0, rd), 2);
      store_reg(rd, 2);
      emit(i_type(0, 0, 3'd0, RCNT, OP_IMM), 3);
      branch_pair(3'd0, ra, ra);
      branch_pair(3'd0, ra, rb);
      branch_pair(3'd1, ra, rb);
      branch_pair(3'd1, ra, ra);
      branch_pair(3'd4, ra, rb);
      branch_pair(3'd4, rb, ra);
      branch_pair(3'd5, rb, ra);
      branch_pair(3'd5, ra, rb);
      store_reg(RCNT, 3);
      jimm = {$random(seed)} % 64;
      target = (prog_len + 3) * 4;
      emit(i_type(target + 1 - jimm, 0, 3'd0, 29, OP_IMM), 4);   // Odd target address
      emit(i_type(jimm, 29, 3'd0, 30, JALR), 4);
      emit(i_type(0, 0, 3'd0, 30, OP_IMM), 4);
      store_reg(30, 4);
      emit(b_type(0, 0, 0, 3'd0), 4);                // Branch to itself ends the program
   endtask

   // ISA-level interpreter, fills the expected fetch and store queues
   function automatic void run_reference();
      logic [`RV_XLEN-1:0] x [32];
      logic [`RV_XLEN-1:0] pc;
      logic [`RV_XLEN-1:0] next_pc;
      logic [`RV_XLEN-1:0] v1;
      logic [`RV_XLEN-1:0] v2;
      logic [`RV_XLEN-1:0] imm_i;
      logic [`RV_XLEN-1:0] imm_s;
      logic [`RV_XLEN-1:0] imm_b;
      logic [`RV_XLEN-1:0] addr;
      logic [31:0]         ins;
      logic [4:0]          rd;
      logic                taken;
      int                  gap;
      int                  prev_gap;
      imem_req_t           fa;
      dmem_req_t           st;
      for (int i = 0; i < 32; i++)
         x[i] = '0;
      pc = `RV_RESET_PC;
      prev_gap = 2;   // Reset state, then the first fetch
      for (int n = 0; n < MAX_STEPS; n++)
      begin
         ins = imem[pc[7:2]];
         fa.addr = pc;
         exp_fetch_q.push_back(fa);
         exp_gap_q.push_back(prev_gap);
         exp_section_q.push_back(section_of[pc[7:2]]);
         rd = ins[11:7];
         v1 = x[ins[19:15]];
         v2 = x[ins[24:20]];
         imm_i = `RV_XLEN'($signed(ins[31:20]));
         imm_s = `RV_XLEN'($signed({ins[31:25], ins[11:7]}));
         imm_b = `RV_XLEN'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
         next_pc = pc + `RV_INSTR_BYTES;
         gap = 5;
         case (ins[6:0])
            OP:
            begin
               if (ins[14:12] == 3'd2)
                  x[rd] = ($signed(v1) < $signed(v2));
               else if (ins[30])
                  x[rd] = v1 - v2;
               else
                  x[rd] = v1 + v2;
            end
            OP_IMM:
            begin
               if (ins[14:12] == 3'd2)
                  x[rd] = ($signed(v1) < $signed(imm_i));
               else
                  x[rd] = v1 + imm_i;
            end
            LUI:
               x[rd] = `RV_XLEN'($signed({ins[31:12], 12'h000}));
            LOAD:
            begin
               gap = 7;
               addr = v1 + imm_i;
               x[rd] = ref_dmem[addr[8:3]];
            end
            STORE:
            begin
               addr = v1 + imm_s;
               st.addr = addr;
               st.wdata = v2;
               st.re = 1'b0;
               st.we = 1'b1;
               exp_store_q.push_back(st);
               ref_dmem[addr[8:3]] = v2;
            end
            BRANCH:
            begin
               gap = 4;
               case (ins[14:12])
                  3'd0:    taken = (v1 == v2);
                  3'd1:    taken = (v1 != v2);
                  3'd4:    taken = ($signed(v1) < $signed(v2));
                  3'd5:    taken = ($signed(v1) >= $signed(v2));
                  default: taken = 1'b0;
               endcase
               if (taken)
                  next_pc = pc + imm_b;
            end
            JALR:
            begin
               next_pc = (v1 + imm_i) & ~`RV_XLEN'(1);
               x[rd] = pc + `RV_INSTR_BYTES;
            end
            default:
               gap = 3;
         endcase
         x[0] = '0;
         if (next_pc == pc)
            break;
         pc = next_pc;
         prev_gap = gap;
      end
   endfunction

   task automatic check_fetch(input imem_req_t got, input imem_req_t exp,
                              input int got_gap, input int exp_gap);
      if (got !== exp)
      begin
         $display("ERR %0t: fetch address %h, expected %h", $time, got.addr, exp.addr);
         test_errors++;
      end
      if (got_gap != exp_gap)
      begin
         $display("ERR %0t: fetch %h came %0d cycles after the previous one, expected %0d",
                  $time, got.addr, got_gap, exp_gap);
         test_errors++;
      end
   endtask

   task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t: store %h to %h, expected %h to %h", $time, got.wdata, got.addr,
                  exp.wdata, exp.addr);
         test_errors++;
      end
   endtask

   task automatic finish_test();
      total_errors += test_errors;
      if (test_errors == 0)
      begin
         tests_passed++;
         $display("test %0d (%s) passed", cur_test, test_name[cur_test]);
      end
      else
      begin
         tests_failed++;
         $display("test %0d (%s) has %0d errors", cur_test, test_name[cur_test], test_errors);
      end
      test_errors = 0;
   endtask

   // Outputs are sampled mid-cycle, away from the clock edge
   always @(negedge CLK)
   begin
      if (!RESET && !run_done)
      begin
         cycle++;
         if (fetches == 0 && (dmem_req.re || dmem_req.we))
         begin
            $display("Data memory was accessed at %0t before the first fetch", $time);
            test_errors++;
         end
         else if (dmem_req.we)
         begin
            if (exp_store_q.size() == 0)
            begin
               $display("A store at %0t was not expected by the reference", $time);
               test_errors++;
            end
            else
               check_store(dmem_req, exp_store_q.pop_front());
         end
         if (u_dut.u_control.state == ST_FETCH)
         begin
            if (exp_section_q[0] != cur_test)
            begin
               finish_test();
               cur_test = exp_section_q[0];
            end
            check_fetch(imem_req, exp_fetch_q.pop_front(), cycle - last_fetch,
                        exp_gap_q.pop_front());
            exp_section_q.delete(0);
            last_fetch = cycle;
            fetches++;
            if (exp_fetch_q.size() == 0)
            begin
               if (exp_store_q.size() != 0)
               begin
                  $display("%0d expected stores never happened", exp_store_q.size());
                  test_errors++;
               end
               finish_test();
               run_done = 1'b1;
            end
         end
      end
   end

   initial
   begin
      RESET = 1'b1;
      imem_rdata = '0;
      dmem_rdata = '0;
      build_program();
      run_reference();
      repeat (4) @(posedge CLK);
      RESET <= 1'b0;
      wait (run_done);
      $display("%0d tests passed, %0d failed, %0d errors, %0d assertion failures",
               tests_passed, tests_failed, total_errors, u_dut.u_props.fail_count);
      if (total_errors == 0 && tests_failed == 0 && u_dut.u_props.fail_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // Worst case is every instruction taking the load path
   initial
   begin
      wait (prog_len != 0);
      #((prog_len * 7 + 50) * CLK_PERIOD);
      $display("The run timed out at %0t before the program reached its end", $time);
      $display("Test failed");
      $finish;
   end

endmodule

/* tb.f */
+incdir+include
source/rv_pkg.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_imm_gen.sv
source/rv_datapath.sv
source/rv_control.sv
source/rv_core.sv
sim/rv_core_props.sv
sim/rv_core_tb.sv
